//--- common/fetch_pkg.sv
package fetch_pkg;

    // ----------------------------------------
    // Fetch configuration
    // ----------------------------------------
    localparam logic [31:0] RESET_PC        = 32'h3000_0000;
    localparam int          MAX_OUTSTANDING = 4;
    localparam int          FETCH_CREDITS   = 4;
    localparam int          QUEUE_DEPTH     = MAX_OUTSTANDING;

    // Counter widths
    localparam int          SLOT_CNT_W      = $clog2(QUEUE_DEPTH + 1);
    localparam int          TRK_CNT_W       = $clog2(MAX_OUTSTANDING + 1);
    localparam int          CREDIT_W        = $clog2(FETCH_CREDITS + 1);

    // ----------------------------------------
    // AXI4 encodings
    // ----------------------------------------
    localparam int          AXI_ID_W        = 4;
    localparam logic [AXI_ID_W-1:0] AXI_FETCH_ID = '0;
    localparam logic [7:0]  AXI_LEN_SINGLE  = 8'd0;
    localparam logic [2:0]  AXI_SIZE_WORD   = 3'b010;
    localparam logic [1:0]  AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0]  AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0]  AXI_RESP_SLVERR = 2'b10;

    // In-flight tracker entry
    typedef struct packed {
        logic [31:0] pc;
        logic        epoch;
    } fetch_req_t;

    // Packet handed towards decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        fault;
        logic        epoch;
    } fetch_packet_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic [31:0]         addr;
        logic [AXI_ID_W-1:0] id;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0]         data;
        logic [1:0]          resp;
        logic                last;
        logic [AXI_ID_W-1:0] id;
    } axi_r_t;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter type item_t = logic [31:0],
    parameter int  DEPTH  = 4
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       clear,
    input  logic                       push,
    input  item_t                      push_data,
    input  logic                       pop,
    output item_t                      pop_data,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    item_t                    mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;

    assign pop_data = mem[rd_ptr];
    assign empty    = (count == 0);
    assign full     = (count == DEPTH);

    // Storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The owner's flow control must keep these from happening
    push_full_a: assert property (@(posedge clock) disable iff (reset || clear)
        push |-> !full);
    pop_empty_a: assert property (@(posedge clock) disable iff (reset || clear)
        pop |-> !empty);

endmodule

//--- fetch/pc_gen.sv
`timescale 1ns/10ps

module pc_gen import fetch_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  redirect_t  redirect,
    input  logic       hold,
    input  logic       req_ready,
    output logic       req_valid,
    output fetch_req_t req,
    output logic       flush
);

    logic [31:0] pc;
    logic        epoch;

    // No request while stalled, or in the cycle decode steers elsewhere
    assign req_valid = !hold && !redirect.valid;

    assign req.pc    = pc;
    assign req.epoch = epoch;

    // Queue drops everything it holds in the redirect cycle
    assign flush = redirect.valid;

    // ----------------------------------------
    // Program counter and epoch
    // ----------------------------------------
    // A redirect lands in the pc register even under hold, so it is
    // kept there and issued once hold drops
    always_ff @(posedge clock) begin
        if (reset) begin
            pc    <= RESET_PC;
            epoch <= 1'b0;
        end else if (redirect.valid) begin
            pc    <= redirect.target;
            epoch <= ~epoch;
        end else if (req_valid && req_ready) begin
            pc <= pc + 32'd4;
        end
    end

    // Fetch addresses stay word aligned
    pc_aligned_a: assert property (@(posedge clock) disable iff (reset)
        req_valid |-> req.pc[1:0] == 2'b00);

endmodule

//--- fetch/axi_fetch_master.sv
`timescale 1ns/10ps

module axi_fetch_master import fetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    input  fetch_req_t            req,
    output logic                  req_ready,
    output logic                  ar_valid,
    output axi_ar_t               ar,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  axi_r_t                r,
    output logic                  r_ready,
    output logic                  pkt_valid,
    output fetch_packet_t         pkt,
    input  logic [SLOT_CNT_W-1:0] slot_free
);

    fetch_req_t            trk_head;
    logic                  trk_empty;
    logic [TRK_CNT_W-1:0]  trk_count;
    logic [SLOT_CNT_W-1:0] in_use;
    logic                  req_fire;
    logic                  ar_fire;

    // Requests in flight plus the beat waiting in the packet register
    assign in_use = SLOT_CNT_W'(trk_count) + SLOT_CNT_W'(pkt_valid);

    assign ar_fire   = ar_valid && ar_ready;
    assign req_ready = (!ar_valid || ar_ready) && (in_use < slot_free);
    assign req_fire  = req_valid && req_ready;

    // Each request owns a queue slot, so R never stalls
    assign r_ready = 1'b1;

    // ----------------------------------------
    // AR channel
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            ar_valid <= 1'b0;
        end else if (req_fire) begin
            ar_valid <= 1'b1;
        end else if (ar_fire) begin
            ar_valid <= 1'b0;
        end
    end

    // Single word, fixed burst
    always_ff @(posedge clock) begin
        if (req_fire) begin
            ar.addr  <= req.pc;
            ar.id    <= AXI_FETCH_ID;
            ar.len   <= AXI_LEN_SINGLE;
            ar.size  <= AXI_SIZE_WORD;
            ar.burst <= AXI_BURST_FIXED;
        end
    end

    // In-flight tracker, oldest entry matches the next R beat
    sync_fifo #(
        .item_t (fetch_req_t),
        .DEPTH  (MAX_OUTSTANDING)
    ) tracker_i (
        .clock     (clock),
        .reset     (reset),
        .clear     (1'b0),
        .push      (req_fire),
        .push_data (req),
        .pop       (r_valid),
        .pop_data  (trk_head),
        .empty     (trk_empty),
        .full      (),
        .count     (trk_count)
    );

    // ----------------------------------------
    // R channel to packet
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= r_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (r_valid) begin
            pkt.pc    <= trk_head.pc;
            pkt.inst  <= r.data;
            pkt.fault <= (r.resp != AXI_RESP_OKAY);
            pkt.epoch <= trk_head.epoch;
        end
    end

    // Memory answers only what was asked, one beat each
    r_tracked_a: assert property (@(posedge clock) disable iff (reset)
        r_valid |-> !trk_empty && r.last);

endmodule

//--- fetch/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue import fetch_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  cur_epoch,
    input  logic                  pkt_valid,
    input  fetch_packet_t         pkt,
    output logic [SLOT_CNT_W-1:0] slot_free,
    input  logic                  credit_return,
    output logic                  out_valid,
    output fetch_packet_t         out_pkt
);

    fetch_packet_t         head;
    logic                  empty;
    logic [SLOT_CNT_W-1:0] count;
    logic [CREDIT_W-1:0]   credits;
    logic                  keep;
    logic                  send;

    // Packets from before the last redirect are thrown away
    assign keep = pkt_valid && (pkt.epoch == cur_epoch) && !flush;

    // Send only with a credit in hand
    assign send = !empty && (credits != '0) && !flush;

    // Free slots, the master reserves from these
    assign slot_free = SLOT_CNT_W'(QUEUE_DEPTH) - count;

    sync_fifo #(
        .item_t (fetch_packet_t),
        .DEPTH  (QUEUE_DEPTH)
    ) buffer_i (
        .clock     (clock),
        .reset     (reset),
        .clear     (flush),
        .push      (keep),
        .push_data (pkt),
        .pop       (send),
        .pop_data  (head),
        .empty     (empty),
        .full      (),
        .count     (count)
    );

    // ----------------------------------------
    // Decode credits
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CREDIT_W'(FETCH_CREDITS);
        end else begin
            case ({credit_return, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Output register, one cycle per packet
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

    always_ff @(posedge clock) begin
        if (send) begin
            out_pkt <= head;
        end
    end

    // Decode never returns more than it was given
    credit_bound_a: assert property (@(posedge clock) disable iff (reset)
        credits <= FETCH_CREDITS);

endmodule

//--- design/fetch_unit_top.sv
`timescale 1ns/10ps

module fetch_unit_top import fetch_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  redirect_t     redirect,
    input  logic          hold,
    output logic          ar_valid,
    output axi_ar_t       ar,
    input  logic          ar_ready,
    input  logic          r_valid,
    input  axi_r_t        r,
    output logic          r_ready,
    output logic          out_valid,
    output fetch_packet_t out_pkt,
    input  logic          credit_return
);

    logic                  req_valid;
    logic                  req_ready;
    fetch_req_t            req;
    logic                  flush;
    logic                  pkt_valid;
    fetch_packet_t         pkt;
    logic [SLOT_CNT_W-1:0] slot_free;

    pc_gen pc_gen_i (
        .clock     (clock),
        .reset     (reset),
        .redirect  (redirect),
        .hold      (hold),
        .req_ready (req_ready),
        .req_valid (req_valid),
        .req       (req),
        .flush     (flush)
    );

    axi_fetch_master master_i (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .slot_free (slot_free)
    );

    // Current epoch is the one pc_gen stamps on new requests
    fetch_queue queue_i (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .cur_epoch     (req.epoch),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt),
        .slot_free     (slot_free),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_pkt       (out_pkt)
    );

endmodule

//--- test/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model import fetch_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    ar_valid,
    input  axi_ar_t ar,
    output logic    ar_ready,
    output logic    r_valid,
    output axi_r_t  r,
    input  logic    r_ready
);

    // Reads in this window answer with SLVERR
    localparam logic [31:0] ERR_BASE  = 32'h3000_1000;
    localparam logic [31:0] ERR_LAST  = 32'h3000_10ff;
    localparam logic [31:0] INST_MASK = 32'ha55a_0000;

    axi_ar_t     pend_q[$];
    int          delay_q[$];
    logic [31:0] lfsr_state;
    axi_ar_t     ar_seen;
    axi_ar_t     head;
    logic        ar_taken;
    logic        beat_taken;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int bits;
        bits = 0;
        for (int i = 0; i < n; i++) begin
            bits       = (bits << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // Sample handshakes on the rising edge, drive R on the falling edge
    initial begin
        lfsr_state = 32'd76834;
        ar_ready   = 1'b1;
        r_valid    = 1'b0;
        r          = '0;
        forever begin
            @(posedge clock);
            ar_taken   = !reset && ar_valid && ar_ready;
            ar_seen    = ar;
            beat_taken = r_valid && r_ready;
            @(negedge clock);
            if (reset) begin
                pend_q.delete();
                delay_q.delete();
                r_valid = 1'b0;
            end else begin
                if (ar_taken) begin
                    pend_q.push_back(ar_seen);
                    delay_q.push_back(rand_bits(2));
                end
                if (beat_taken || !r_valid) begin
                    r_valid = 1'b0;
                    if (pend_q.size() > 0) begin
                        if (delay_q[0] == 0) begin
                            head = pend_q.pop_front();
                            void'(delay_q.pop_front());
                            r.data  = head.addr ^ INST_MASK;
                            r.resp  = (head.addr >= ERR_BASE && head.addr <= ERR_LAST) ?
                                      AXI_RESP_SLVERR : AXI_RESP_OKAY;
                            r.last  = 1'b1;
                            r.id    = head.id;
                            r_valid = 1'b1;
                        end else begin
                            delay_q[0] = delay_q[0] - 1;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- test/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam logic [31:0] INST_MASK      = 32'ha55a_0000;
    localparam logic [31:0] ERR_BASE       = 32'h3000_1000;
    localparam logic [31:0] ERR_LAST       = 32'h3000_10ff;
    localparam int          SETTLE         = 32;
    localparam int          RANDOM_PACKETS = 200;
    // Nominal cycles per test, in run order
    localparam int TEST_LENGTH = 16 + (3 * SETTLE + 12) + 12 + (3 * SETTLE + 20) + 12
                                 + 2 * RANDOM_PACKETS;

    logic          clock = 1'b0;
    logic          reset;
    redirect_t     redirect;
    logic          hold;
    logic          ar_valid;
    axi_ar_t       ar;
    logic          ar_ready;
    logic          r_valid;
    axi_r_t        r;
    logic          r_ready;
    logic          out_valid;
    fetch_packet_t out_pkt;
    logic          credit_return;

    logic          credit_en;
    logic          credit_rand;
    logic [31:0]   lfsr_state;
    logic [31:0]   exp_pc = RESET_PC;
    logic          exp_epoch = 1'b0;
    int            received = 0;
    int            returned = 0;
    int            fault_seen = 0;
    int            check_errors = 0;
    int            test_errors = 0;

    always #50 clock = ~clock;

    fetch_unit_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .redirect      (redirect),
        .hold          (hold),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r             (r),
        .r_ready       (r_ready),
        .out_valid     (out_valid),
        .out_pkt       (out_pkt),
        .credit_return (credit_return)
    );

    axi_mem_model mem_i (
        .clock    (clock),
        .reset    (reset),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

    function automatic logic in_error_region(input logic [31:0] addr);
        return (addr >= ERR_BASE) && (addr <= ERR_LAST);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int bits;
        bits = 0;
        for (int i = 0; i < n; i++) begin
            bits       = (bits << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // ----------------------------------------
    // Checker, pc model follows redirects
    // ----------------------------------------
    always @(posedge clock) begin
        if (!reset) begin
            if (out_valid) begin
                if (out_pkt.pc !== exp_pc) begin
                    $display("ERROR %0t ns: out_pkt.pc expected %h, got %h",
                             $time, exp_pc, out_pkt.pc);
                    check_errors++;
                end
                if (out_pkt.inst !== (exp_pc ^ INST_MASK)) begin
                    $display("ERROR %0t ns: out_pkt.inst expected %h, got %h",
                             $time, exp_pc ^ INST_MASK, out_pkt.inst);
                    check_errors++;
                end
                if (out_pkt.fault !== in_error_region(exp_pc)) begin
                    $display("ERROR %0t ns: out_pkt.fault expected %b, got %b",
                             $time, in_error_region(exp_pc), out_pkt.fault);
                    check_errors++;
                end
                if (out_pkt.epoch !== exp_epoch) begin
                    $display("ERROR %0t ns: out_pkt.epoch expected %b, got %b",
                             $time, exp_epoch, out_pkt.epoch);
                    check_errors++;
                end
                if (out_pkt.fault) begin
                    fault_seen++;
                end
                exp_pc = exp_pc + 32'd4;
                received++;
            end
            if (ar_valid && ar.size !== AXI_SIZE_WORD) begin
                $display("ERROR %0t ns: ar.size expected %h, got %h",
                         $time, AXI_SIZE_WORD, ar.size);
                check_errors++;
            end
            // Single beat per fetch
            if (ar_valid && ar.len !== 8'd0) begin
                $display("ERROR %0t ns: ar.len expected %h, got %h",
                         $time, 8'd0, ar.len);
                check_errors++;
            end
            if (r_ready !== 1'b1) begin
                $display("ERROR %0t ns: r_ready expected %b, got %b",
                         $time, 1'b1, r_ready);
                check_errors++;
            end
            // Packet seen in the redirect cycle still belongs to the old path
            if (redirect.valid) begin
                exp_pc    = redirect.target;
                exp_epoch = ~exp_epoch;
            end
        end
    end

    // Decode side, one credit back per packet taken
    initial begin
        credit_return = 1'b0;
        lfsr_state    = 32'd76834;
        forever begin
            @(negedge clock);
            credit_return = 1'b0;
            if (!reset && credit_en && received > returned) begin
                if (!credit_rand || rand_bits(1) == 1) begin
                    credit_return = 1'b1;
                    returned++;
                end
            end
        end
    end

    initial begin
        repeat ((8 + TEST_LENGTH) * 4) @(posedge clock);
        $display("Watchdog expired at %0t ns, the tests did not finish", $time);
        $display("Testbench failed");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clock);
    endtask

    task automatic wait_packets(input int n);
        int target;
        int waited;
        target = received + n;
        waited = 0;
        while (received < target && waited < n * 16 + 32) begin
            @(negedge clock);
            waited++;
        end
        if (received < target) begin
            $display("Timed out at %0t ns waiting for packets, %0d of %0d arrived",
                     $time, n - (target - received), n);
            test_errors++;
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(negedge clock);
        redirect = '0;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic sequential_fetch();
        wait_packets(16);
    endtask

    task automatic credit_backpressure();
        int base;
        hold = 1'b1;
        idle(SETTLE);
        if (received != returned) begin
            $display("Credits were still owed after the pipeline drained at %0t ns", $time);
            test_errors++;
        end
        credit_en <= 1'b0;
        hold = 1'b0;
        base = received;
        idle(2 * SETTLE);
        if (received - base != FETCH_CREDITS) begin
            $display("Without credit returns %0d packets came out instead of %0d",
                     received - base, FETCH_CREDITS);
            test_errors++;
        end
        credit_en <= 1'b1;
        wait_packets(12);
    endtask

    task automatic redirect_fetch();
        send_redirect(32'h3000_0800);
        wait_packets(12);
    endtask

    task automatic hold_fetch();
        int base;
        hold = 1'b1;
        idle(SETTLE);
        base = received;
        idle(SETTLE);
        if (received != base) begin
            $display("Packets kept coming while hold was high at %0t ns", $time);
            test_errors++;
        end
        hold = 1'b0;
        wait_packets(8);
        // Redirect while stalled must still steer the next fetch
        hold = 1'b1;
        idle(SETTLE);
        send_redirect(32'h3000_0c00);
        idle(4);
        hold = 1'b0;
        wait_packets(8);
    endtask

    task automatic error_response();
        int base;
        base = fault_seen;
        send_redirect(32'h3000_10f0);
        wait_packets(12);
        if (fault_seen - base != 4) begin
            $display("Error region gave %0d faulted packets instead of 4", fault_seen - base);
            test_errors++;
        end
    endtask

    task automatic random_latency();
        credit_rand <= 1'b1;
        send_redirect(32'h3000_2000);
        wait_packets(RANDOM_PACKETS);
        credit_rand <= 1'b0;
    endtask

    initial begin
        reset       = 1'b1;
        hold        = 1'b0;
        redirect    = '0;
        credit_en   = 1'b1;
        credit_rand = 1'b0;
        repeat (8) @(negedge clock);
        reset = 1'b0;
        sequential_fetch();
        credit_backpressure();
        redirect_fetch();
        hold_fetch();
        error_response();
        random_latency();
        $display("Errors: checker %0d, tests %0d, packets %0d",
                 check_errors, test_errors, received);
        if (check_errors + test_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- fetch_unit_top.f
common/fetch_pkg.sv
design/sync_fifo.sv
fetch/pc_gen.sv
fetch/axi_fetch_master.sv
fetch/fetch_queue.sv
design/fetch_unit_top.sv
test/axi_mem_model.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f fetch_unit_top.f -o fetch_sim || { echo "Build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
